// ==== verilog/lr35902_pkg.sv ====
package lr35902_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and basic bus types.
	//////////////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Register field encoding, as in opcode bits [5:3] and [2:0].
	typedef enum logic [2:0] {
		REG_B, REG_C, REG_D, REG_E,
		REG_H, REG_L, REG_HL, REG_A
	} reg_idx_t;

	// ALU group, in opcode bits [5:3] order.
	typedef enum logic [2:0] {
		ADD, ADC, SUB, SBC,
		AND, XOR, OR, CP
	} alu_op_t;

	// Upper nibble of F, MSB first.
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	// Four-phase external bus cycle.
	typedef enum logic [1:0] {
		PH_ADDR, PH_STROBE, PH_SAMPLE, PH_RELEASE
	} bus_phase_t;

endpackage

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
	import lr35902_pkg::*;

	// Request, held stable until done.
	logic  req;
	logic  we;
	addr_t adr;
	data_t wdata;

	// Response.
	// done is one cycle; rdata valid with it on a read.
	data_t rdata;
	logic  done;

	modport requester (
		output req, we, adr, wdata,
		input  rdata, done
	);

	modport arbiter (
		input  req, we, adr, wdata,
		output rdata, done
	);
endinterface

// ==== verilog/fetch_stream_if.sv ====
`timescale 1ns/1ps

interface fetch_stream_if;
	import lr35902_pkg::*;

	// Buffered instruction byte.
	logic  valid;
	data_t byte_data;

	// Consume strobe and PC reload.
	logic  take;
	logic  redirect;
	addr_t target;

	modport producer (
		output valid, byte_data,
		input  take, redirect, target
	);

	modport consumer (
		input  valid, byte_data,
		output take, redirect, target
	);
endinterface

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                clk,
	input  logic                reset,
	mem_req_if.arbiter          exec_port,
	mem_req_if.arbiter          fetch_port,
	output lr35902_pkg::addr_t  adr,
	output lr35902_pkg::data_t  dout,
	output logic                ddrv,
	output logic                read,
	output logic                write,
	input  lr35902_pkg::data_t  data
);
	import lr35902_pkg::*;

	bus_phase_t phase;
	logic       busy;
	logic       owner_exec;
	logic       we_q;
	data_t      rdata_q;
	logic       sel_exec;
	logic       done_now;

	// Controller wins a tie with the fetch unit.
	assign sel_exec = exec_port.req;

	// Last cycle of a bus cycle.
	assign done_now = busy && (phase == PH_RELEASE);

	assign exec_port.done  = done_now && owner_exec;
	assign fetch_port.done = done_now && !owner_exec;
	assign exec_port.rdata  = rdata_q;
	assign fetch_port.rdata = rdata_q;

	//////////////////////////////////////////////////////////////////////
	// Grant and phase sequencing.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase      <= PH_ADDR;
			busy       <= 1'b0;
			owner_exec <= 1'b0;
			we_q       <= 1'b0;
			adr        <= '0;
			dout       <= '0;
			ddrv       <= 1'b0;
			read       <= 1'b0;
			write      <= 1'b0;
		end
		else if (!busy)
		begin
			// Idle bus, so latch the winner and put its address out.
			if (exec_port.req || fetch_port.req)
			begin
				busy       <= 1'b1;
				phase      <= PH_ADDR;
				owner_exec <= sel_exec;
				adr        <= sel_exec ? exec_port.adr : fetch_port.adr;
				dout       <= sel_exec ? exec_port.wdata : fetch_port.wdata;
				we_q       <= sel_exec ? exec_port.we : fetch_port.we;
				ddrv       <= sel_exec ? exec_port.we : fetch_port.we;
			end
		end
		else
		begin
			case (phase)
				PH_ADDR:
				begin
					phase <= PH_STROBE;
					read  <= !we_q;
					write <= we_q;
				end
				PH_STROBE:
				begin
					// Write pulse is one phase wide.
					phase <= PH_SAMPLE;
					write <= 1'b0;
				end
				PH_SAMPLE:
				begin
					phase <= PH_RELEASE;
					read  <= 1'b0;
				end
				default:
				begin
					busy <= 1'b0;
					ddrv <= 1'b0;
				end
			endcase
		end
	end

	// Read byte captured at the end of the sample phase.
	always_ff @(posedge clk)
	begin
		if (busy && phase == PH_SAMPLE)
			rdata_q <= data;
	end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter lr35902_pkg::addr_t RESET_PC = '0
) (
	input  logic             clk,
	input  logic             reset,
	mem_req_if.requester     mem,
	fetch_stream_if.producer stream
);
	import lr35902_pkg::*;

	addr_t pc;
	addr_t fetch_adr;
	data_t buf_data;
	logic  buf_valid;
	logic  pending;
	logic  stale;
	logic  consume;
	logic  fill;
	logic  buf_free;
	logic  issue;

	assign consume = stream.valid && stream.take;
	// Returning byte goes to the buffer unless a redirect dropped it.
	assign fill = mem.done && !stale && !stream.redirect;
	// Buffer is empty after this cycle.
	assign buf_free = (!buf_valid || consume) && !fill;
	// One read at a time, back to back when possible.
	assign issue = (!pending || mem.done) && buf_free && !stream.redirect;

	assign stream.valid     = buf_valid;
	assign stream.byte_data = buf_data;
	assign mem.req   = pending;
	assign mem.adr   = fetch_adr;
	assign mem.we    = 1'b0;
	assign mem.wdata = '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc        <= RESET_PC;
			buf_valid <= 1'b0;
			pending   <= 1'b0;
			stale     <= 1'b0;
		end
		else
		begin
			if (mem.done)
			begin
				pending <= 1'b0;
				stale   <= 1'b0;
			end
			if (issue)
			begin
				pending <= 1'b1;
				pc      <= pc + 16'd1;
			end
			if (stream.redirect)
			begin
				// Read in flight is now from the old path.
				pc        <= stream.target;
				buf_valid <= 1'b0;
				if (pending && !mem.done)
					stale <= 1'b1;
			end
			else if (fill)
				buf_valid <= 1'b1;
			else if (consume)
				buf_valid <= 1'b0;
		end
	end

	// Address and byte registers.
	always_ff @(posedge clk)
	begin
		if (issue)
			fetch_adr <= pc;
		if (fill)
			buf_data <= mem.rdata;
	end

endmodule

// ==== verilog/alu8.sv ====
`timescale 1ns/1ps

module alu8 (
	input  lr35902_pkg::alu_op_t op,
	input  lr35902_pkg::data_t   a,
	input  lr35902_pkg::data_t   b,
	input  lr35902_pkg::flags_t  flags_in,
	output lr35902_pkg::data_t   result,
	output lr35902_pkg::flags_t  flags_out,
	input  logic                 incdec,
	input  logic                 dec
);
	import lr35902_pkg::*;

	logic [8:0] sum;
	logic [4:0] half;
	logic       cin;

	// Carry in only for ADC and SBC.
	assign cin = (op == ADC || op == SBC) ? flags_in.c : 1'b0;

	always_comb
	begin
		sum       = '0;
		half      = '0;
		result    = '0;
		flags_out = '0;
		if (incdec)
		begin
			// Single operand in b, carry passes through.
			sum  = dec ? {1'b0, b} - 9'd1 : {1'b0, b} + 9'd1;
			half = dec ? {1'b0, b[3:0]} - 5'd1 : {1'b0, b[3:0]} + 5'd1;
			result      = sum[7:0];
			flags_out.n = dec;
			flags_out.h = half[4];
			flags_out.c = flags_in.c;
		end
		else
		begin
			case (op)
				ADD, ADC:
				begin
					sum  = {1'b0, a} + {1'b0, b} + {8'd0, cin};
					half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
					result      = sum[7:0];
					flags_out.h = half[4];
					flags_out.c = sum[8];
				end
				AND:
				begin
					result      = a & b;
					flags_out.h = 1'b1;
				end
				XOR: result = a ^ b;
				OR:  result = a | b;
				default:
				begin
					// SUB, SBC and CP, bit 8 is the borrow.
					sum  = {1'b0, a} - {1'b0, b} - {8'd0, cin};
					half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
					result      = sum[7:0];
					flags_out.n = 1'b1;
					flags_out.h = half[4];
					flags_out.c = sum[8];
				end
			endcase
		end
		flags_out.z = (result == '0);
	end

endmodule

// ==== verilog/exec_control.sv ====
`timescale 1ns/1ps

module exec_control #(
	parameter lr35902_pkg::addr_t RESET_PC = '0
) (
	input  logic             clk,
	input  logic             reset,
	mem_req_if.requester     mem,
	fetch_stream_if.consumer stream
);
	import lr35902_pkg::*;

	typedef enum logic [2:0] {S_OPCODE, S_IMM_LO, S_IMM_HI, S_READ_HL, S_WRITE_HL} state_t;

	state_t   state;
	data_t    rf [8];
	flags_t   f;
	data_t    op, imml, wdata_q;
	addr_t    pc_next, adr_q;
	logic     req_q, we_q;
	data_t    cur_op, operand, alu_b, alu_res, rf_wdata;
	flags_t   alu_flags;
	reg_idx_t dst, src, rf_idx;
	logic     is_ld, is_ldi, is_alu, is_alu_r, is_alu_i, is_incdec, is_jr, is_jp;
	logic     cond_ok, got, exec, rf_we;

	alu8 u_alu (
		.op       (alu_op_t'(cur_op[5:3])),
		.a        (rf[REG_A]),
		.b        (alu_b),
		.flags_in (f),
		.result   (alu_res),
		.flags_out(alu_flags),
		.incdec   (is_incdec),
		.dec      (cur_op[0])
	);

	assign got = stream.valid && stream.take;
	// Bytes are taken only while the FSM expects one.
	assign stream.take = (state == S_OPCODE) || (state == S_IMM_LO) || (state == S_IMM_HI);
	assign mem.req   = req_q;
	assign mem.we    = we_q;
	assign mem.adr   = adr_q;
	assign mem.wdata = wdata_q;

	//////////////////////////////////////////////////////////////////////
	// Decode, operand select and writeback.
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Opcode straight from the stream in its first cycle.
		cur_op    = (state == S_OPCODE) ? stream.byte_data : op;
		dst       = reg_idx_t'(cur_op[5:3]);
		src       = reg_idx_t'(cur_op[2:0]);
		is_ld     = cur_op[7:6] == 2'b01;
		is_ldi    = cur_op[7:6] == 2'b00 && src == REG_HL && dst != REG_HL;
		is_alu_r  = cur_op[7:6] == 2'b10;
		is_alu_i  = cur_op[7:6] == 2'b11 && src == REG_HL;
		is_alu    = is_alu_r || is_alu_i;
		is_incdec = cur_op[7:6] == 2'b00 && cur_op[2:1] == 2'b10 && dst != REG_HL;
		is_jr     = cur_op == 8'h18 || (cur_op[7:5] == 3'b001 && cur_op[2:0] == 3'b000);
		is_jp     = cur_op == 8'hc3;
		// NZ, Z, NC, C.
		case (cur_op[4:3])
			2'd0: cond_ok = !f.z;
			2'd1: cond_ok = f.z;
			2'd2: cond_ok = !f.c;
			default: cond_ok = f.c;
		endcase
		if (cur_op == 8'h18)
			cond_ok = 1'b1;
		case (state)
			S_IMM_LO:  operand = stream.byte_data;
			S_READ_HL: operand = mem.rdata;
			default:   operand = rf[src];
		endcase
		alu_b = is_incdec ? rf[dst] : operand;
		// Instruction completes with its operand in hand.
		exec = (state == S_OPCODE && got && src != REG_HL) || (state == S_IMM_LO && got)
			|| (state == S_READ_HL && mem.done);
		rf_we = exec && ((((is_ld || is_ldi) && dst != REG_HL) || is_incdec)
			|| (is_alu && alu_op_t'(cur_op[5:3]) != CP));
		rf_idx   = is_alu ? REG_A : dst;
		rf_wdata = (is_ld || is_ldi) ? operand : alu_res;
		// JP once the high byte is in, JR on the offset byte.
		stream.redirect = got && ((state == S_IMM_HI) || (state == S_IMM_LO && is_jr && cond_ok));
		if (state == S_IMM_HI)
			stream.target = {stream.byte_data, imml};
		else
			stream.target = pc_next + 16'd1 + {{8{stream.byte_data[7]}}, stream.byte_data};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_OPCODE;
			for (int i = 0; i < 8; i++)
				rf[i] <= '0;
			f       <= '0;
			pc_next <= RESET_PC;
			req_q   <= 1'b0;
			we_q    <= 1'b0;
		end
		else
		begin
			if (rf_we)
				rf[rf_idx] <= rf_wdata;
			if (exec && (is_alu || is_incdec))
				f <= alu_flags;
			// Address of the next stream byte.
			if (stream.redirect)
				pc_next <= stream.target;
			else if (got)
				pc_next <= pc_next + 16'd1;
			if (mem.done)
				req_q <= 1'b0;
			case (state)
				S_OPCODE:
					if (got)
					begin
						if ((is_ld || is_alu_r) && src == REG_HL && !(is_ld && dst == REG_HL))
						begin
							req_q <= 1'b1;
							we_q  <= 1'b0;
							state <= S_READ_HL;
						end
						else if (is_ld && dst == REG_HL && src != REG_HL)
						begin
							req_q <= 1'b1;
							we_q  <= 1'b1;
							state <= S_WRITE_HL;
						end
						else if (is_ldi || is_alu_i || is_jr || is_jp)
							state <= S_IMM_LO;
					end
				S_IMM_LO:
					if (got)
						state <= is_jp ? S_IMM_HI : S_OPCODE;
				S_IMM_HI:
					if (got)
						state <= S_OPCODE;
				default:
					if (mem.done)
						state <= S_OPCODE;
			endcase
		end
	end

	// Opcode, immediate and (HL) access payload.
	always_ff @(posedge clk)
	begin
		if (state == S_OPCODE && got)
		begin
			op      <= stream.byte_data;
			adr_q   <= {rf[REG_H], rf[REG_L]};
			wdata_q <= rf[src];
		end
		if (state == S_IMM_LO && got)
			imml <= stream.byte_data;
	end

endmodule

// ==== verilog/lr35902_core.sv ====
`timescale 1ns/1ps

module lr35902_core #(
	parameter lr35902_pkg::addr_t RESET_PC = '0
) (
	input  logic               clk,
	input  logic               reset,
	output lr35902_pkg::addr_t adr,
	input  lr35902_pkg::data_t data,
	output lr35902_pkg::data_t dout,
	output logic               ddrv,
	output logic               read,
	output logic               write
);

	// Controller and fetch share one bus.
	mem_req_if      exec_bus ();
	mem_req_if      fetch_bus ();
	fetch_stream_if stream ();

	bus_arbiter u_arbiter (
		.clk       (clk),
		.reset     (reset),
		.exec_port (exec_bus.arbiter),
		.fetch_port(fetch_bus.arbiter),
		.adr       (adr),
		.dout      (dout),
		.ddrv      (ddrv),
		.read      (read),
		.write     (write),
		.data      (data)
	);

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk   (clk),
		.reset (reset),
		.mem   (fetch_bus.requester),
		.stream(stream.producer)
	);

	exec_control #(.RESET_PC(RESET_PC)) u_exec (
		.clk   (clk),
		.reset (reset),
		.mem   (exec_bus.requester),
		.stream(stream.consumer)
	);

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	// Free running clock.
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Power-on reset, released on a falling edge.
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic         clk,
	input  logic         reset,
	input  logic [15:0]  adr,
	input  logic [7:0]   dout,
	input  logic         ddrv,
	input  logic         read,
	input  logic         write,
	// Expected values, compared while check is high.
	input  logic         check,
	input  logic [127:0] name,
	input  logic [7:0]   exp_res,
	input  logic [7:0]   exp_flags,
	output int           writes,
	output int           checks,
	output int           errors
);

	logic [7:0] res_got;
	logic [7:0] flag_got;
	logic       res_seen;
	logic       flag_seen;
	logic       reset_q;

	initial
	begin
		writes  = 0;
		checks  = 0;
		errors  = 0;
		reset_q = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus monitor.
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		// Bus must be idle once reset has been seen for a full cycle.
		if (reset && reset_q && (read || write || ddrv || dout !== 8'h00))
		begin
			$display("Error: bus strobe, data drive or data out active during reset at %0t",
				$time);
			errors = errors + 1;
		end
		if (read && write)
		begin
			$display("Error: read and write strobes high together at %0t", $time);
			errors = errors + 1;
		end
		// Data bus is driven for the whole write and never on a read.
		if (write && !ddrv)
		begin
			$display("Error: write strobe without data drive at %0t", $time);
			errors = errors + 1;
		end
		if (read && ddrv)
		begin
			$display("Error: data bus driven during a read strobe at %0t", $time);
			errors = errors + 1;
		end
		reset_q = reset;
		if (reset)
		begin
			writes    = 0;
			res_seen  = 1'b0;
			flag_seen = 1'b0;
		end
		else if (write)
		begin
			writes = writes + 1;
			// Result byte.
			if (adr == 16'hc000)
			begin
				res_got  = dout;
				res_seen = 1'b1;
			end
			// Flag byte.
			else if (adr == 16'hc001)
			begin
				flag_got  = dout;
				flag_seen = 1'b1;
			end
			else
			begin
				$display("Error: %0s wrote %02h to unexpected address %04h", name, dout, adr);
				errors = errors + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare against the expected values.
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (check)
		begin
			checks = checks + 2;
			if (!res_seen)
			begin
				$display("Error: %0s never stored its result byte", name);
				errors = errors + 1;
			end
			else if (res_got !== exp_res)
			begin
				$display("Fail %0s result: expected %02h, actual %02h", name, exp_res, res_got);
				errors = errors + 1;
			end
			if (!flag_seen)
			begin
				$display("Error: %0s never stored its flag byte", name);
				errors = errors + 1;
			end
			else if (flag_got !== exp_flags)
			begin
				$display("Fail %0s flags: expected %02h, actual %02h", name, exp_flags, flag_got);
				errors = errors + 1;
			end
		end
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int NUM_TESTS       = 27;
	localparam int CYCLES_PER_TEST = 400;

	// Program shapes.
	localparam int K_ALU_R  = 0;
	localparam int K_ALU_I  = 1;
	localparam int K_ALU_M  = 2;
	localparam int K_INCDEC = 3;
	localparam int K_LD     = 4;
	localparam int K_JP     = 5;

	logic         clk;
	logic         clk_reset;
	logic         test_reset;
	logic         dut_reset;
	logic [15:0]  adr;
	logic [7:0]   bus_data;
	logic [7:0]   dout;
	logic         ddrv;
	logic         read;
	logic         write;
	logic         check;
	logic [127:0] cur_name;
	logic [7:0]   exp_res;
	logic [7:0]   exp_flags;
	int           writes;
	int           checks;
	int           errors;

	// Test table.
	logic [127:0] t_name [NUM_TESTS];
	int           t_kind [NUM_TESTS];
	logic [7:0]   t_op   [NUM_TESTS];
	logic [7:0]   t_x    [NUM_TESTS];
	logic [7:0]   t_y    [NUM_TESTS];
	logic [7:0]   t_res  [NUM_TESTS];
	logic         t_z    [NUM_TESTS];
	logic         t_c    [NUM_TESTS];
	int           n_tests;

	logic [7:0]  mem [0:65535];
	logic [15:0] wp;
	logic [31:0] rng_state;

	assign dut_reset = clk_reset | test_reset;

	tb_clock #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) u_clock (
		.clk  (clk),
		.reset(clk_reset)
	);

	lr35902_core #(.RESET_PC(16'h0000)) DUT (
		.clk  (clk),
		.reset(dut_reset),
		.adr  (adr),
		.data (bus_data),
		.dout (dout),
		.ddrv (ddrv),
		.read (read),
		.write(write)
	);

	tb_checker u_checker (
		.clk      (clk),
		.reset    (dut_reset),
		.adr      (adr),
		.dout     (dout),
		.ddrv     (ddrv),
		.read     (read),
		.write    (write),
		.check    (check),
		.name     (cur_name),
		.exp_res  (exp_res),
		.exp_flags(exp_flags),
		.writes   (writes),
		.checks   (checks),
		.errors   (errors)
	);

	// Bus memory, serviced on the falling edge.
	always @(negedge clk)
	begin
		if (read)
			bus_data <= mem[adr];
		if (write)
			mem[adr] = dout;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference arithmetic and table helpers.
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Returns {z, c, A}. Carry is a carry out or a borrow.
	function automatic logic [9:0] alu_expect(input logic [2:0] op, input logic [7:0] x,
		input logic [7:0] y, input logic cin);
		int         t;
		logic [7:0] r;
		logic       c;
		logic       z;
		case (op)
			3'd0: t = int'(x) + int'(y);
			3'd1: t = int'(x) + int'(y) + int'(cin);
			3'd2, 3'd7: t = int'(x) - int'(y);
			3'd3: t = int'(x) - int'(y) - int'(cin);
			3'd4: t = int'(x & y);
			3'd5: t = int'(x ^ y);
			default: t = int'(x | y);
		endcase
		r = t[7:0];
		c = (t < 0) || (t > 255);
		z = (r == 8'h00);
		// CP leaves A alone.
		if (op == 3'd7)
			r = x;
		return {z, c, r};
	endfunction

	task automatic add_entry(input logic [127:0] name, input int kind, input logic [7:0] op,
		input logic [7:0] x, input logic [7:0] y, input logic [7:0] res, input logic z,
		input logic c);
		t_name[n_tests] = name;
		t_kind[n_tests] = kind;
		t_op[n_tests]   = op;
		t_x[n_tests]    = x;
		t_y[n_tests]    = y;
		t_res[n_tests]  = res;
		t_z[n_tests]    = z;
		t_c[n_tests]    = c;
		n_tests = n_tests + 1;
	endtask

	// Random operands; carry is always set before the operation.
	task automatic add_random(input logic [127:0] name, input int kind, input logic [7:0] op);
		logic [7:0] x;
		logic [7:0] y;
		logic [9:0] e;
		rng_state = xorshift32(rng_state);
		x = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		y = rng_state[7:0];
		e = alu_expect(op[5:3], x, y, 1'b1);
		add_entry(name, kind, op, x, y, e[7:0], e[9], e[8]);
	endtask

	task automatic emit_seq(input int n, input logic [127:0] seq);
		for (int k = n - 1; k >= 0; k--)
		begin
			mem[wp] = seq[8*k +: 8];
			wp = wp + 16'd1;
		end
	endtask

	// Fill, then write the program of entry i from address 0.
	task automatic load_program(input int i);
		logic [15:0] here;
		for (int a = 0; a < 65536; a++)
			mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
		wp = 16'h0000;
		// LD A,FF and ADD A,A leave C set.
		emit_seq(3, {8'h3e, 8'hff, 8'h87});
		case (t_kind[i])
			K_ALU_R: emit_seq(5, {8'h3e, t_x[i], 8'h06, t_y[i], t_op[i]});
			K_ALU_I: emit_seq(4, {8'h3e, t_x[i], t_op[i], t_y[i]});
			K_ALU_M:
			begin
				mem[16'h8010] = t_y[i];
				emit_seq(7, {8'h3e, t_x[i], 8'h26, 8'h80, 8'h2e, 8'h10, t_op[i]});
			end
			K_INCDEC: emit_seq(4, {8'h06, t_x[i], t_op[i], 8'h78});
			K_LD:
			begin
				// Copy through C into the result address.
				mem[{8'h80, t_y[i]}] = t_x[i];
				emit_seq(10, {8'h26, 8'h80, 8'h2e, t_y[i], t_op[i], 8'h26, 8'hc0, 8'h2e,
					8'h00, 8'h71});
			end
			default:
			begin
				// JP over a store to C002.
				emit_seq(7, {8'h3e, t_x[i], 8'h26, 8'hc0, 8'h2e, 8'h02, t_op[i]});
				here = wp + 16'd3;
				emit_seq(3, {here[7:0], here[15:8], 8'h77});
			end
		endcase
		if (t_kind[i] != K_LD)
			emit_seq(5, {8'h26, 8'hc0, 8'h2e, 8'h00, 8'h77});
		// Flag byte is Z*80 + C, stored to C001.
		emit_seq(12, {8'h3e, 8'h00, 8'h20, 8'h02, 8'h3e, 8'h80, 8'h30, 8'h01, 8'h3c,
			8'h2e, 8'h01, 8'h77});
		here = wp;
		emit_seq(3, {8'hc3, here[7:0], here[15:8]});
	endtask

	task automatic build_table();
		n_tests = 0;
		rng_state = 32'd16296;
		add_random("ADD B", K_ALU_R, 8'h80);
		add_random("ADC B", K_ALU_R, 8'h88);
		add_random("SUB B", K_ALU_R, 8'h90);
		add_random("SBC B", K_ALU_R, 8'h98);
		add_random("AND B", K_ALU_R, 8'ha0);
		add_random("XOR B", K_ALU_R, 8'ha8);
		add_random("OR B", K_ALU_R, 8'hb0);
		add_random("CP B", K_ALU_R, 8'hb8);
		add_random("ADD d8", K_ALU_I, 8'hc6);
		add_random("ADC d8", K_ALU_I, 8'hce);
		add_random("SUB d8", K_ALU_I, 8'hd6);
		add_random("SBC d8", K_ALU_I, 8'hde);
		add_random("AND d8", K_ALU_I, 8'he6);
		add_random("XOR d8", K_ALU_I, 8'hee);
		add_random("OR d8", K_ALU_I, 8'hf6);
		add_random("CP d8", K_ALU_I, 8'hfe);
		add_random("ADC (HL)", K_ALU_M, 8'h8e);
		add_random("SBC (HL)", K_ALU_M, 8'h9e);
		// The four Z and C combinations.
		add_entry("CP equal", K_ALU_I, 8'hfe, 8'h42, 8'h42, 8'h42, 1'b1, 1'b0);
		add_entry("CP below", K_ALU_I, 8'hfe, 8'h10, 8'h20, 8'h10, 1'b0, 1'b1);
		add_entry("CP above", K_ALU_I, 8'hfe, 8'h90, 8'h20, 8'h90, 1'b0, 1'b0);
		add_entry("ADD wrap", K_ALU_R, 8'h80, 8'h80, 8'h80, 8'h00, 1'b1, 1'b1);
		// INC and DEC keep the preset carry.
		add_entry("INC B wrap", K_INCDEC, 8'h04, 8'hff, 8'h00, 8'h00, 1'b1, 1'b1);
		add_entry("DEC B wrap", K_INCDEC, 8'h05, 8'h00, 8'h00, 8'hff, 1'b0, 1'b1);
		add_entry("INC B half", K_INCDEC, 8'h04, 8'h0f, 8'h00, 8'h10, 1'b0, 1'b1);
		add_entry("LD via (HL)", K_LD, 8'h4e, 8'ha5, 8'h37, 8'ha5, 1'b0, 1'b1);
		add_entry("JP skip", K_JP, 8'hc3, 8'h5a, 8'h00, 8'h5a, 1'b0, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus loop.
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		test_reset = 1'b1;
		check      = 1'b0;
		bus_data   = 8'h00;
		cur_name   = '0;
		exp_res    = 8'h00;
		exp_flags  = 8'h00;
		build_table();
		for (int i = 0; i < n_tests; i++)
		begin
			@(negedge clk);
			test_reset = 1'b1;
			// One edge in reset clears the strobes first.
			@(negedge clk);
			load_program(i);
			repeat (4) @(negedge clk);
			test_reset = 1'b0;
			while (writes < 2)
				@(negedge clk);
			cur_name  = t_name[i];
			exp_res   = t_res[i];
			exp_flags = {t_z[i], 6'd0, t_c[i]};
			check     = 1'b1;
			@(negedge clk);
			check = 1'b0;
		end
		repeat (2) @(negedge clk);
		$display("Tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog, sized from the table length.
	initial
	begin
		repeat (NUM_TESTS * CYCLES_PER_TEST + 20) @(posedge clk);
		$display("Error: run did not finish within %0d cycles",
			NUM_TESTS * CYCLES_PER_TEST + 20);
		$display("Tests %0d, checks %0d, errors %0d", n_tests, checks, errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== list.f ====
verilog/lr35902_pkg.sv
verilog/mem_req_if.sv
verilog/fetch_stream_if.sv
verilog/bus_arbiter.sv
verilog/fetch_unit.sv
verilog/alu8.sv
verilog/exec_control.sv
verilog/lr35902_core.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv
